// File: red_pitaya_radiobox.f
common/rb_pkg.sv
hw/rb_regs.sv
hw/rb_enable_seq.sv
osc/rb_dds.sv
osc/rb_mix_multadd.sv
hw/rb_led_mag.sv
hw/red_pitaya_radiobox.sv
sim/radiobox_asserts.sv
sim/tb_radiobox.sv

// File: run_sim.sh
#!/bin/sh
# build and run the RadioBox simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_radiobox -f red_pitaya_radiobox.f
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/Vtb_radiobox)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation returned status $status"
  exit 1
fi

if echo "$out" | grep -q "All tests passed"; then
  exit 0
fi
exit 1

// File: sim/tb_radiobox.sv
// RadioBox testbench
`timescale 1ns/1ps

module tb_radiobox;

  logic        clk_adc_125mhz;
  logic        adc_rstn_i;
  logic [31:0] sys_addr_i;
  logic [31:0] sys_wdata_i;
  logic        sys_wen_i;
  logic        sys_ren_i;
  logic [31:0] sys_rdata_o;
  logic        sys_ack_o;
  logic        rb_en_o;
  logic [15:0] rb_out_ch_o;
  logic        rb_leds_en_o;
  logic [7:0]  rb_leds_data_o;

  red_pitaya_radiobox dut (.*);

  initial begin
    clk_adc_125mhz = 1'b0;
    forever #4 clk_adc_125mhz = ~clk_adc_125mhz;   // 125 MHz
  end

  // ------------------------------------------------------------------------
  // helpers
  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [47:0] got, input logic [47:0] exp);
    if (got !== exp) begin
      $display("** Error %s: got %h, expected %h", name, got, exp);
      fail_run("value mismatch");
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk_adc_125mhz);
  endtask

  task automatic wait_ack();
    int n;
    n = 0;
    while (!sys_ack_o) begin
      @(negedge clk_adc_125mhz);
      n++;
      if (n > 16) fail_run("no bus acknowledge");
    end
  endtask

  task automatic bus_write(input logic [19:0] a, input logic [31:0] d);
    @(negedge clk_adc_125mhz);
    sys_addr_i  = {12'h000, a};
    sys_wdata_i = d;
    sys_wen_i   = 1'b1;                            // one cycle request
    @(negedge clk_adc_125mhz);
    sys_wen_i   = 1'b0;
    wait_ack();
  endtask

  task automatic bus_read(input logic [19:0] a, output logic [31:0] d);
    @(negedge clk_adc_125mhz);
    sys_addr_i = {12'h000, a};
    sys_ren_i  = 1'b1;
    @(negedge clk_adc_125mhz);
    sys_ren_i  = 1'b0;
    wait_ack();
    d = sys_rdata_o;                               // valid with ack
  endtask

  task automatic wait_out_valid(input logic level);
    int n;
    n = 0;
    while (rb_en_o !== level) begin
      @(negedge clk_adc_125mhz);
      n++;
      if (n > 100) fail_run("rb_en_o did not reach the expected level");
    end
  endtask

  // poll status until clock enable and core reset_n both show the level
  task automatic poll_core_state(input logic level);
    logic [31:0] st;
    int          n;
    n = 0;
    bus_read(rb_pkg::REG_STATUS, st);
    while (st[1:0] !== {level, level}) begin
      n++;
      if (n > 30) fail_run("enable sequence did not finish");
      bus_read(rb_pkg::REG_STATUS, st);
    end
  endtask

  // bar pattern from the led rules: upper four for positive, lower four mirrored
  function automatic logic [7:0] bar_pattern(input logic [15:0] v);
    logic [14:0] m;
    int          n;
    m = v[15] ? ~v[14:0] : v[14:0];
    n = m[14] ? 4 : (|m[14:12]) ? 3 : (|m[14:10]) ? 2 : (|m || v[15]) ? 1 : 0;
    if (!v[15]) return 8'(((1 << n) - 1) << 4);
    return (8'hf0 >> n) & 8'h0f;
  endfunction

  // top 16 bits of the signed sample times the doubled gain plus the offset
  function automatic logic [15:0] mixer_top(input logic [15:0] s, input logic [31:0] g,
                                            input logic [47:0] o);
    logic signed [63:0] a64;
    logic signed [63:0] g64;
    logic signed [63:0] p64;
    logic        [47:0] sum;
    a64 = {{48{s[15]}}, s};
    g64 = {{31{g[31]}}, g, 1'b0};                  // gain with zero below
    p64 = a64 * g64;
    sum = p64[47:0] + o;
    return sum[47:32];
  endfunction

  // ------------------------------------------------------------------------
  // constant tone with the oscillator magnitude leds
  task automatic run_tone(input logic [47:0] x);
    logic [31:0] g;
    logic [47:0] o;
    logic [15:0] xs;
    logic [15:0] exp_out;
    logic [31:0] st;
    g         = $urandom;
    o[31:0]   = $urandom;
    o[47:32]  = 16'($urandom);
    xs        = x[47:32];
    exp_out   = mixer_top(xs, g, o);
    bus_write(rb_pkg::REG_OSC1_INC_LO, 32'h0);
    bus_write(rb_pkg::REG_OSC1_INC_HI, 32'h0);
    bus_write(rb_pkg::REG_OSC1_OFS_LO, x[31:0]);
    bus_write(rb_pkg::REG_OSC1_OFS_HI, {16'h0, xs});
    bus_write(rb_pkg::REG_OSC1_MIX_GAIN, g);
    bus_write(rb_pkg::REG_OSC1_MIX_OFS_LO, o[31:0]);
    bus_write(rb_pkg::REG_OSC1_MIX_OFS_HI, {16'h0, o[47:32]});
    bus_write(rb_pkg::REG_LED_CTRL, 32'(rb_pkg::LED_OSC1_MAG));
    bus_write(rb_pkg::REG_CTRL, 32'h1);
    wait_out_valid(1'b1);
    idle_cycles(rb_pkg::MIX_LATENCY + 4);          // pipeline full of one value
    check_value("rb_out_ch_o", 48'(rb_out_ch_o), 48'(exp_out));
    bus_read(rb_pkg::REG_STATUS, st);
    check_value("status osc1_zero", 48'(st[rb_pkg::STAT_OSC1_ZERO]), 48'(xs == 16'h0));
    check_value("rb_leds_en_o", 48'(rb_leds_en_o), 48'h1);
    check_value("rb_leds_data_o", 48'(rb_leds_data_o), 48'(bar_pattern(xs)));
    check_value("status leds", 48'(st[31:24]), 48'(bar_pattern(xs)));
    bus_write(rb_pkg::REG_LED_CTRL, 32'(rb_pkg::LED_DISABLED));
    idle_cycles(2);
    check_value("rb_leds_en_o", 48'(rb_leds_en_o), 48'h0);
    bus_write(rb_pkg::REG_LED_CTRL, 32'(rb_pkg::LED_OFF));
    idle_cycles(2);                                // divider restarts at zero
    check_value("rb_leds_en_o", 48'(rb_leds_en_o), 48'h1);
    check_value("rb_leds_data_o", 48'(rb_leds_data_o), 48'h0);
    bus_write(rb_pkg::REG_LED_CTRL, 32'(rb_pkg::LED_DISABLED));
    bus_write(rb_pkg::REG_LED_CTRL, 32'(rb_pkg::LED_MIX1_MAG));
    idle_cycles(2);                                // mixer magnitude on the next refresh
    check_value("rb_leds_data_o mix", 48'(rb_leds_data_o), 48'(bar_pattern(exp_out)));
    bus_write(rb_pkg::REG_CTRL, 32'h0);
    poll_core_state(1'b0);
    wait_out_valid(1'b0);
  endtask

  // ------------------------------------------------------------------------
  // watchdog, generous against a few thousand cycles of tests
  initial begin
    repeat (20000) @(posedge clk_adc_125mhz);
    fail_run("watchdog timeout, the run did not finish");
  end

  initial begin
    logic [31:0] d;
    logic [31:0] v;
    logic [19:0] regs [8];
    logic [15:0] inc_hi;
    logic [15:0] prev;
    logic [15:0] step;
    void'($urandom(61));
    adc_rstn_i  = 1'b0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    repeat (4) @(negedge clk_adc_125mhz);
    adc_rstn_i  = 1'b1;
    // after reset
    check_value("sys_ack_o", 48'(sys_ack_o), 48'h0);
    check_value("rb_en_o", 48'(rb_en_o), 48'h0);
    check_value("rb_leds_en_o", 48'(rb_leds_en_o), 48'h0);
    bus_read(rb_pkg::REG_STATUS, d);
    check_value("status", 48'(d), 48'h0);
    // register readback
    regs = '{rb_pkg::REG_LED_CTRL, rb_pkg::REG_OSC1_INC_LO, rb_pkg::REG_OSC1_INC_HI,
             rb_pkg::REG_OSC1_OFS_LO, rb_pkg::REG_OSC1_OFS_HI, rb_pkg::REG_OSC1_MIX_GAIN,
             rb_pkg::REG_OSC1_MIX_OFS_LO, rb_pkg::REG_OSC1_MIX_OFS_HI};
    foreach (regs[i]) begin
      v = $urandom;
      bus_write(regs[i], v);
      bus_read(regs[i], d);
      if (regs[i][2] && regs[i] != rb_pkg::REG_LED_CTRL) v = v & 32'h0000ffff;  // HI halves
      check_value("sys_rdata_o", 48'(d), 48'(v));
      bus_write(regs[i], 32'h0);
    end
    v = $urandom & ~32'(1 << rb_pkg::CTRL_ENABLE);  // box stays off
    bus_write(rb_pkg::REG_CTRL, v);
    bus_read(rb_pkg::REG_CTRL, d);
    check_value("sys_rdata_o ctrl", 48'(d), 48'(v));
    bus_write(rb_pkg::REG_CTRL, 32'h0);
    bus_read(20'h00100, d);                        // hole in the map
    check_value("sys_rdata_o unmapped", 48'(d), 48'h0);
    // enable sequence
    bus_write(rb_pkg::REG_CTRL, 32'h1);
    poll_core_state(1'b1);
    wait_out_valid(1'b1);
    bus_write(rb_pkg::REG_CTRL, 32'h0);
    poll_core_state(1'b0);
    wait_out_valid(1'b0);
    // constant tones, random and with zero top bits
    run_tone({16'($urandom), $urandom});
    run_tone({16'h0000, $urandom});
    // sawtooth
    inc_hi = 16'($urandom);
    step   = mixer_top(inc_hi, 32'h80000000, 48'h0);  // low 32 product bits stay zero
    bus_write(rb_pkg::REG_OSC1_MIX_GAIN, 32'h80000000);  // minus one on the top 16 bits
    bus_write(rb_pkg::REG_OSC1_MIX_OFS_LO, 32'h0);
    bus_write(rb_pkg::REG_OSC1_MIX_OFS_HI, 32'h0);
    bus_write(rb_pkg::REG_OSC1_OFS_LO, 32'h0);
    bus_write(rb_pkg::REG_OSC1_OFS_HI, 32'h0);
    bus_write(rb_pkg::REG_OSC1_INC_HI, {16'h0, inc_hi});
    bus_write(rb_pkg::REG_CTRL, 32'h1);
    wait_out_valid(1'b1);
    prev = rb_out_ch_o;
    repeat (10) begin
      @(negedge clk_adc_125mhz);
      check_value("rb_out_ch_o step", 48'(16'(rb_out_ch_o - prev)), 48'(step));
      prev = rb_out_ch_o;
    end
    v = $urandom;
    bus_write(rb_pkg::REG_OSC1_OFS_HI, v);
    bus_write(rb_pkg::REG_CTRL, 32'h11);           // enable plus resync
    idle_cycles(rb_pkg::MIX_LATENCY + 4);
    check_value("rb_out_ch_o resync", 48'(rb_out_ch_o),
                48'(mixer_top(v[15:0], 32'h80000000, 48'h0)));
    bus_write(rb_pkg::REG_CTRL, 32'h3);            // enable with osc1 held in reset
    wait_out_valid(1'b0);
    check_value("rb_out_ch_o osc1 reset", 48'(rb_out_ch_o),
                48'(mixer_top(16'h0, 32'h80000000, 48'h0)));
    $display("All tests passed");
    $finish;
  end

endmodule

// File: sim/radiobox_asserts.sv
// RadioBox protocol assertions
`timescale 1ns/1ps

module radiobox_asserts (
  input logic       clk_adc_125mhz,
  input logic       adc_rstn_i,
  input logic       sys_wen_i,
  input logic       sys_ren_i,
  input logic       sys_ack_o,
  input logic       rb_en_o,
  input logic       rb_leds_en_o,
  input logic [7:0] rb_leds_data_o
);

  // ack exactly one cycle after every request cycle
  ack_follows_req: assert property (@(posedge clk_adc_125mhz) disable iff (!adc_rstn_i)
    (sys_wen_i || sys_ren_i) |=> sys_ack_o)
    else $error("bus request without acknowledge in the next cycle");

  // no ack unless a request came the cycle before
  ack_needs_req: assert property (@(posedge clk_adc_125mhz) disable iff (!adc_rstn_i)
    sys_ack_o |-> $past(sys_wen_i || sys_ren_i))
    else $error("acknowledge without a request");

  // dark leds whenever the indicator is off
  leds_dark_when_off: assert property (@(posedge clk_adc_125mhz)
    !rb_leds_en_o |-> (rb_leds_data_o == 8'h00))
    else $error("led data driven while led enable is low");

  // first reset edge clears the pipeline, so check from the second one on
  no_valid_in_reset: assert property (@(posedge clk_adc_125mhz)
    (!adc_rstn_i && $past(!adc_rstn_i)) |-> !rb_en_o)
    else $error("output valid during reset");

endmodule

bind red_pitaya_radiobox radiobox_asserts u_asserts (
  .clk_adc_125mhz(clk_adc_125mhz),
  .adc_rstn_i    (adc_rstn_i),
  .sys_wen_i     (sys_wen_i),
  .sys_ren_i     (sys_ren_i),
  .sys_ack_o     (sys_ack_o),
  .rb_en_o       (rb_en_o),
  .rb_leds_en_o  (rb_leds_en_o),
  .rb_leds_data_o(rb_leds_data_o)
);

// File: hw/red_pitaya_radiobox.sv
// RadioBox top level
`timescale 1ns/1ps

module red_pitaya_radiobox (
  input  logic                        clk_adc_125mhz,  // 125 MHz adc clock
  input  logic                        adc_rstn_i,      // sync, active low
  input  logic [rb_pkg::BUS_W-1:0]    sys_addr_i,
  input  logic [rb_pkg::BUS_W-1:0]    sys_wdata_i,
  input  logic                        sys_wen_i,
  input  logic                        sys_ren_i,
  output logic [rb_pkg::BUS_W-1:0]    sys_rdata_o,
  output logic                        sys_ack_o,
  output logic                        rb_en_o,         // output samples valid
  output logic [rb_pkg::SAMPLE_W-1:0] rb_out_ch_o,
  output logic                        rb_leds_en_o,
  output logic [7:0]                  rb_leds_data_o
);

  logic                          ctrl_enable;
  logic                          ctrl_reset_osc1;
  logic                          ctrl_resync;
  logic [rb_pkg::LED_CTRL_W-1:0] led_mode;
  logic [rb_pkg::PHASE_W-1:0]    osc1_inc;
  logic [rb_pkg::PHASE_W-1:0]    osc1_ofs;
  logic [rb_pkg::PHASE_W-1:0]    mix_ofs;
  logic [rb_pkg::BUS_W-1:0]      mix_gain;
  logic                          core_clk_en;
  logic                          core_rst_n;
  logic                          osc1_rst_n;     // core reset plus osc1 reset bit
  logic [rb_pkg::SAMPLE_W-1:0]   sample;
  logic                          sample_vld;
  logic [rb_pkg::PHASE_W-1:0]    mix_out;
  logic                          mix_vld;

  assign osc1_rst_n = core_rst_n & ~ctrl_reset_osc1;

  // --------------------------------------------------------------------------
  // control
  rb_regs u_regs (
    .clk_adc_125mhz   (clk_adc_125mhz),
    .adc_rstn_i       (adc_rstn_i),
    .sys_addr_i       (sys_addr_i),
    .sys_wdata_i      (sys_wdata_i),
    .sys_wen_i        (sys_wen_i),
    .sys_ren_i        (sys_ren_i),
    .sys_rdata_o      (sys_rdata_o),
    .sys_ack_o        (sys_ack_o),
    .core_clk_en_i    (core_clk_en),
    .core_rst_n_i     (core_rst_n),
    .leds_en_i        (rb_leds_en_o),
    .osc1_vld_i       (sample_vld),
    .mix_vld_i        (mix_vld),
    .osc1_sample_i    (sample),
    .leds_data_i      (rb_leds_data_o),
    .ctrl_enable_o    (ctrl_enable),
    .ctrl_reset_osc1_o(ctrl_reset_osc1),
    .ctrl_resync_o    (ctrl_resync),
    .led_mode_o       (led_mode),
    .osc1_inc_o       (osc1_inc),
    .osc1_ofs_o       (osc1_ofs),
    .mix_ofs_o        (mix_ofs),
    .mix_gain_o       (mix_gain)
  );

  rb_enable_seq u_enable_seq (
    .clk_adc_125mhz(clk_adc_125mhz),
    .adc_rstn_i    (adc_rstn_i),
    .ctrl_enable_i (ctrl_enable),
    .core_clk_en_o (core_clk_en),
    .core_rst_n_o  (core_rst_n)
  );

  // --------------------------------------------------------------------------
  // carrier datapath
  rb_dds u_osc1_dds (
    .clk_adc_125mhz(clk_adc_125mhz),
    .clk_en_i      (core_clk_en),
    .rst_n_i       (osc1_rst_n),
    .resync_i      (ctrl_resync),
    .inc_i         (osc1_inc),
    .ofs_i         (osc1_ofs),
    .sample_o      (sample),
    .sample_vld_o  (sample_vld)
  );

  rb_mix_multadd u_osc1_mix (
    .clk_adc_125mhz(clk_adc_125mhz),
    .clk_en_i      (core_clk_en),
    .sclr_i        (~core_rst_n),                 // cleared while the core sleeps
    .a_i           (sample),
    .gain_i        (mix_gain),
    .ofs_i         (mix_ofs),
    .vld_i         (sample_vld),
    .mix_o         (mix_out),
    .vld_o         (mix_vld)
  );

  rb_led_mag u_led_mag (
    .clk_adc_125mhz(clk_adc_125mhz),
    .adc_rstn_i    (adc_rstn_i),
    .core_rst_n_i  (core_rst_n),
    .mode_i        (led_mode),
    .rb_en_i       (mix_vld),
    .osc1_i        (sample),
    .mix1_i        (mix_out[rb_pkg::PHASE_W-1 -: rb_pkg::SAMPLE_W]),
    .leds_en_o     (rb_leds_en_o),
    .leds_data_o   (rb_leds_data_o)
  );

  assign rb_en_o     = mix_vld;
  assign rb_out_ch_o = mix_out[rb_pkg::PHASE_W-1 -: rb_pkg::SAMPLE_W];  // top 16 bits

endmodule

// File: hw/rb_led_mag.sv
// RadioBox LED magnitude indicator
`timescale 1ns/1ps

module rb_led_mag (
  input  logic                          clk_adc_125mhz,
  input  logic                          adc_rstn_i,
  input  logic                          core_rst_n_i,
  input  logic [rb_pkg::LED_CTRL_W-1:0] mode_i,
  input  logic                          rb_en_i,       // mixer output valid
  input  logic [rb_pkg::SAMPLE_W-1:0]   osc1_i,
  input  logic [rb_pkg::SAMPLE_W-1:0]   mix1_i,
  output logic                          leds_en_o,
  output logic [7:0]                    leds_data_o
);

  logic [rb_pkg::LED_CTR_W-1:0] led_ctr;   // update divider

  // thermometer code of a 15 bit magnitude
  function automatic logic [3:0] bar_level(input logic [14:0] m);
    logic [3:0] bar;
    bar = 4'b0000;
    if (m[14]) bar = 4'b1111;
    else if (|m[14:12]) bar = 4'b0111;
    else if (|m[14:10]) bar = 4'b0011;
    else if (|m) bar = 4'b0001;
    return bar;
  endfunction

  // positive values light the upper four, negative ones the lower four
  function automatic logic [7:0] fct_mag(input logic [15:0] val);
    logic [3:0] lvl;
    logic [7:0] leds;
    if (!val[15]) begin
      lvl  = bar_level(val[14:0]);
      leds = {lvl, 4'b0000};
    end else begin
      lvl  = bar_level(~val[14:0]);                   // -1 maps to level zero
      leds = {4'b0000, 1'b1, lvl[1], lvl[2], lvl[3]};  // mirrored, led3 always on
    end
    return leds;
  endfunction

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i || !core_rst_n_i) begin
      leds_en_o   <= 1'b0;
      leds_data_o <= '0;
      led_ctr     <= '0;
    end else if ((mode_i != rb_pkg::LED_DISABLED) && rb_en_i) begin
      leds_en_o <= 1'b1;                             // indicator owns the leds
      led_ctr   <= led_ctr + 1'b1;
      if (led_ctr == '0) begin                       // refresh once per divider wrap
        case (mode_i)
          rb_pkg::LED_OFF:      leds_data_o <= '0;
          rb_pkg::LED_MIX1_MAG: leds_data_o <= fct_mag(mix1_i);
          rb_pkg::LED_OSC1_MAG: leds_data_o <= fct_mag(osc1_i);
          default:              leds_data_o <= '0;   // unassigned modes stay dark
        endcase
      end
    end else begin
      leds_en_o   <= 1'b0;
      leds_data_o <= '0;
      led_ctr     <= '0;
    end
  end

endmodule

// File: osc/rb_mix_multadd.sv
// OSC1 mixer multiply-add pipeline
`timescale 1ns/1ps

module rb_mix_multadd (
  input  logic                               clk_adc_125mhz,
  input  logic                               clk_en_i,
  input  logic                               sclr_i,      // active high clear
  input  logic signed [rb_pkg::SAMPLE_W-1:0] a_i,
  input  logic        [rb_pkg::BUS_W-1:0]    gain_i,
  input  logic        [rb_pkg::PHASE_W-1:0]  ofs_i,
  input  logic                               vld_i,
  output logic        [rb_pkg::PHASE_W-1:0]  mix_o,
  output logic                               vld_o
);

  localparam int LAT = rb_pkg::MIX_LATENCY;

  logic signed [rb_pkg::GAIN_W-1:0]                 gain_ext;  // gain with zero lsb
  logic signed [rb_pkg::SAMPLE_W+rb_pkg::GAIN_W-1:0] prod;     // full signed product
  logic        [rb_pkg::PHASE_W-1:0]                madd;
  logic        [rb_pkg::PHASE_W-1:0]                pipe_q [LAT];
  logic        [LAT-1:0]                            vld_q;     // valid rides beside data

  assign gain_ext = {gain_i, 1'b0};
  assign prod     = a_i * gain_ext;                  // both operands signed
  assign madd     = prod[rb_pkg::PHASE_W-1:0] + ofs_i;  // keep low 48 bits

  // --------------------------------------------------------------------------
  // seven stage delay, advances only on enabled cycles
  always_ff @(posedge clk_adc_125mhz) begin
    if (sclr_i) begin
      vld_q <= '0;
      for (int i = 0; i < LAT; i++) begin
        pipe_q[i] <= '0;
      end
    end else if (clk_en_i) begin
      pipe_q[0] <= madd;
      for (int i = 1; i < LAT; i++) begin
        pipe_q[i] <= pipe_q[i-1];
      end
      vld_q <= {vld_q[LAT-2:0], vld_i};
    end
  end

  assign mix_o = pipe_q[LAT-1];
  assign vld_o = vld_q[LAT-1];

endmodule

// File: osc/rb_dds.sv
// OSC1 phase accumulator
`timescale 1ns/1ps

module rb_dds (
  input  logic                        clk_adc_125mhz,
  input  logic                        clk_en_i,
  input  logic                        rst_n_i,          // core reset and osc1 reset
  input  logic                        resync_i,
  input  logic [rb_pkg::PHASE_W-1:0]  inc_i,
  input  logic [rb_pkg::PHASE_W-1:0]  ofs_i,
  output logic [rb_pkg::SAMPLE_W-1:0] sample_o,
  output logic                        sample_vld_o
);

  logic [rb_pkg::PHASE_W-1:0] acc;         // running phase
  logic [rb_pkg::PHASE_W-1:0] phase;       // phase with offset applied

  assign phase = acc + ofs_i;              // wraps modulo 2^48

  always_ff @(posedge clk_adc_125mhz) begin
    if (!rst_n_i) begin
      acc          <= '0;
      sample_o     <= '0;
      sample_vld_o <= 1'b0;
    end else if (clk_en_i) begin
      if (resync_i) begin
        acc <= '0;                         // parked at zero phase
      end else begin
        acc <= acc + inc_i;
      end
      // the waveform is the phase itself, a sawtooth
      sample_o     <= phase[rb_pkg::PHASE_W-1 -: rb_pkg::SAMPLE_W];
      sample_vld_o <= 1'b1;                // valid from the first enabled cycle
    end
  end

endmodule

// File: hw/rb_enable_seq.sv
// RadioBox enable sequencer
`timescale 1ns/1ps

module rb_enable_seq (
  input  logic clk_adc_125mhz,
  input  logic adc_rstn_i,
  input  logic ctrl_enable_i,
  output logic core_clk_en_o,
  output logic core_rst_n_o
);

  logic       enable_last;                 // enable of the previous cycle
  logic [1:0] hold_ctr;                    // settle time between the two steps

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      enable_last   <= 1'b0;
      core_clk_en_o <= 1'b0;
      core_rst_n_o  <= 1'b0;
      hold_ctr      <= '0;
    end else begin
      enable_last <= ctrl_enable_i;
      if (ctrl_enable_i != enable_last) begin
        hold_ctr <= 2'(rb_pkg::ENABLE_HOLD);        // restart on any edge of enable
        if (ctrl_enable_i) begin
          core_clk_en_o <= 1'b1;                   // clocks first when waking up
        end else begin
          core_rst_n_o <= 1'b0;                    // reset first when going to sleep
        end
      end else if (hold_ctr != '0) begin
        hold_ctr <= hold_ctr - 2'd1;
      end else if (ctrl_enable_i) begin
        core_rst_n_o <= 1'b1;                      // release the core
      end else begin
        core_clk_en_o <= 1'b0;                     // stop the clocks
      end
    end
  end

endmodule

// File: hw/rb_regs.sv
// RadioBox register bank
`timescale 1ns/1ps

module rb_regs (
  input  logic                          clk_adc_125mhz,
  input  logic                          adc_rstn_i,      // sync, active low
  input  logic [rb_pkg::BUS_W-1:0]      sys_addr_i,
  input  logic [rb_pkg::BUS_W-1:0]      sys_wdata_i,
  input  logic                          sys_wen_i,
  input  logic                          sys_ren_i,
  output logic [rb_pkg::BUS_W-1:0]      sys_rdata_o,
  output logic                          sys_ack_o,
  input  logic                          core_clk_en_i,
  input  logic                          core_rst_n_i,
  input  logic                          leds_en_i,
  input  logic                          osc1_vld_i,
  input  logic                          mix_vld_i,
  input  logic [rb_pkg::SAMPLE_W-1:0]   osc1_sample_i,
  input  logic [7:0]                    leds_data_i,
  output logic                          ctrl_enable_o,
  output logic                          ctrl_reset_osc1_o,
  output logic                          ctrl_resync_o,
  output logic [rb_pkg::LED_CTRL_W-1:0] led_mode_o,
  output logic [rb_pkg::PHASE_W-1:0]    osc1_inc_o,
  output logic [rb_pkg::PHASE_W-1:0]    osc1_ofs_o,
  output logic [rb_pkg::PHASE_W-1:0]    mix_ofs_o,
  output logic [rb_pkg::BUS_W-1:0]      mix_gain_o
);

  logic [rb_pkg::ADDR_DEC_W-1:0] addr;   // decoded part of the bus address
  logic [rb_pkg::BUS_W-1:0]      ctrl;
  logic [rb_pkg::BUS_W-1:0]      led_ctrl;
  logic [rb_pkg::BUS_W-1:0]      inc_lo;
  logic [rb_pkg::HI_W-1:0]       inc_hi;
  logic [rb_pkg::BUS_W-1:0]      ofs_lo;
  logic [rb_pkg::HI_W-1:0]       ofs_hi;
  logic [rb_pkg::BUS_W-1:0]      mix_gain;
  logic [rb_pkg::BUS_W-1:0]      mix_ofs_lo;
  logic [rb_pkg::HI_W-1:0]       mix_ofs_hi;
  logic [rb_pkg::BUS_W-1:0]      status;
  logic [rb_pkg::BUS_W-1:0]      rdata_mux;

  assign addr = sys_addr_i[rb_pkg::ADDR_DEC_W-1:0];

  // --------------------------------------------------------------------------
  // register writes, effective at the sampling edge
  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      ctrl       <= '0;
      led_ctrl   <= '0;
      inc_lo     <= '0;
      inc_hi     <= '0;
      ofs_lo     <= '0;
      ofs_hi     <= '0;
      mix_gain   <= '0;
      mix_ofs_lo <= '0;
      mix_ofs_hi <= '0;
    end else if (sys_wen_i) begin
      case (addr)
        rb_pkg::REG_CTRL:            ctrl       <= sys_wdata_i;
        rb_pkg::REG_LED_CTRL:        led_ctrl   <= sys_wdata_i;
        rb_pkg::REG_OSC1_INC_LO:     inc_lo     <= sys_wdata_i;
        rb_pkg::REG_OSC1_INC_HI:     inc_hi     <= sys_wdata_i[rb_pkg::HI_W-1:0];
        rb_pkg::REG_OSC1_OFS_LO:     ofs_lo     <= sys_wdata_i;
        rb_pkg::REG_OSC1_OFS_HI:     ofs_hi     <= sys_wdata_i[rb_pkg::HI_W-1:0];
        rb_pkg::REG_OSC1_MIX_GAIN:   mix_gain   <= sys_wdata_i;
        rb_pkg::REG_OSC1_MIX_OFS_LO: mix_ofs_lo <= sys_wdata_i;
        rb_pkg::REG_OSC1_MIX_OFS_HI: mix_ofs_hi <= sys_wdata_i[rb_pkg::HI_W-1:0];
        default: ;                                     // status and holes ignore writes
      endcase
    end
  end

  // status snapshot, taken every cycle
  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      status <= '0;
    end else begin
      status                              <= '0;
      status[rb_pkg::STAT_CLK_EN]         <= core_clk_en_i;
      status[rb_pkg::STAT_RESET]          <= core_rst_n_i;
      status[rb_pkg::STAT_LEDS_EN]        <= leds_en_i;
      status[rb_pkg::STAT_OSC1_ZERO]      <= osc1_vld_i && (osc1_sample_i == '0);  // only valid samples
      status[rb_pkg::STAT_OSC1_VALID]     <= osc1_vld_i;
      status[rb_pkg::STAT_OSC1_MIX_VALID] <= mix_vld_i;
      status[rb_pkg::STAT_LED_LSB +: 8]   <= leds_data_i;
    end
  end

  // --------------------------------------------------------------------------
  // read mux, unmapped reads return zero
  always_comb begin
    rdata_mux = '0;
    case (addr)
      rb_pkg::REG_CTRL:            rdata_mux = ctrl;
      rb_pkg::REG_STATUS:          rdata_mux = status;
      rb_pkg::REG_LED_CTRL:        rdata_mux = led_ctrl;
      rb_pkg::REG_OSC1_INC_LO:     rdata_mux = inc_lo;
      rb_pkg::REG_OSC1_INC_HI:     rdata_mux[rb_pkg::HI_W-1:0] = inc_hi;
      rb_pkg::REG_OSC1_OFS_LO:     rdata_mux = ofs_lo;
      rb_pkg::REG_OSC1_OFS_HI:     rdata_mux[rb_pkg::HI_W-1:0] = ofs_hi;
      rb_pkg::REG_OSC1_MIX_GAIN:   rdata_mux = mix_gain;
      rb_pkg::REG_OSC1_MIX_OFS_LO: rdata_mux = mix_ofs_lo;
      rb_pkg::REG_OSC1_MIX_OFS_HI: rdata_mux[rb_pkg::HI_W-1:0] = mix_ofs_hi;
      default: ;
    endcase
  end

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      sys_ack_o <= 1'b0;
    end else begin
      sys_ack_o <= sys_wen_i | sys_ren_i;              // one cycle after every request
    end
  end

  always_ff @(posedge clk_adc_125mhz) begin
    if (sys_ren_i) begin
      sys_rdata_o <= rdata_mux;                        // valid together with ack
    end
  end

  assign ctrl_enable_o     = ctrl[rb_pkg::CTRL_ENABLE];
  assign ctrl_reset_osc1_o = ctrl[rb_pkg::CTRL_RESET_OSC1];
  assign ctrl_resync_o     = ctrl[rb_pkg::CTRL_OSC1_RESYNC];
  assign led_mode_o        = led_ctrl[rb_pkg::LED_CTRL_W-1:0];
  assign osc1_inc_o        = {inc_hi, inc_lo};
  assign osc1_ofs_o        = {ofs_hi, ofs_lo};
  assign mix_ofs_o         = {mix_ofs_hi, mix_ofs_lo};
  assign mix_gain_o        = mix_gain;

endmodule

// File: common/rb_pkg.sv
// RadioBox shared constants
package rb_pkg;

  // --------------------------------------------------------------------------
  // widths
  localparam int BUS_W      = 32;                 // system bus data
  localparam int ADDR_DEC_W = 20;                 // decoded low address bits
  localparam int PHASE_W    = 48;                 // dds phase and increment
  localparam int SAMPLE_W   = 16;                 // oscillator and output samples
  localparam int GAIN_W     = 33;                 // mixer gain with zero lsb appended
  localparam int HI_W       = 16;                 // bits kept in HI registers

  // --------------------------------------------------------------------------
  // register offsets
  localparam logic [ADDR_DEC_W-1:0] REG_CTRL            = 20'h00000;
  localparam logic [ADDR_DEC_W-1:0] REG_STATUS          = 20'h00004;  // read only
  localparam logic [ADDR_DEC_W-1:0] REG_LED_CTRL        = 20'h0001C;
  localparam logic [ADDR_DEC_W-1:0] REG_OSC1_INC_LO     = 20'h00020;
  localparam logic [ADDR_DEC_W-1:0] REG_OSC1_INC_HI     = 20'h00024;
  localparam logic [ADDR_DEC_W-1:0] REG_OSC1_OFS_LO     = 20'h00028;
  localparam logic [ADDR_DEC_W-1:0] REG_OSC1_OFS_HI     = 20'h0002C;
  localparam logic [ADDR_DEC_W-1:0] REG_OSC1_MIX_GAIN   = 20'h00030;  // signed
  localparam logic [ADDR_DEC_W-1:0] REG_OSC1_MIX_OFS_LO = 20'h00038;
  localparam logic [ADDR_DEC_W-1:0] REG_OSC1_MIX_OFS_HI = 20'h0003C;

  // control bits
  localparam int CTRL_ENABLE      = 0;            // box on
  localparam int CTRL_RESET_OSC1  = 1;            // hold osc1 in reset
  localparam int CTRL_OSC1_RESYNC = 4;            // phase accumulator held at zero

  // status bits
  localparam int STAT_CLK_EN         = 0;
  localparam int STAT_RESET          = 1;         // core reset_n
  localparam int STAT_LEDS_EN        = 2;
  localparam int STAT_OSC1_ZERO      = 4;
  localparam int STAT_OSC1_VALID     = 5;
  localparam int STAT_OSC1_MIX_VALID = 6;
  localparam int STAT_LED_LSB        = 24;        // 31:24 mirror the leds

  // --------------------------------------------------------------------------
  // led indicator modes
  localparam int LED_CTRL_W = 4;
  localparam logic [LED_CTRL_W-1:0] LED_DISABLED = 4'd0;  // leds untouched
  localparam logic [LED_CTRL_W-1:0] LED_OFF      = 4'd1;  // all dark
  localparam logic [LED_CTRL_W-1:0] LED_MIX1_MAG = 4'd2;  // mixer magnitude
  localparam logic [LED_CTRL_W-1:0] LED_OSC1_MAG = 4'd3;  // oscillator magnitude

  // timing
  localparam int MIX_LATENCY = 7;                 // multiply-add pipeline depth
  localparam int ENABLE_HOLD = 3;                 // sequencer counter load
  localparam int LED_CTR_W   = 20;                // led update divider, about 120 Hz

endpackage
